/* multi_core_settings.svh */
/*
 * Size and width settings for the multi-core wrapper.
 * Include in any file that sizes ports or storage.
 */
`ifndef MULTI_CORE_SETTINGS_SVH
`define MULTI_CORE_SETTINGS_SVH

// number of core tiles.
`define CORE_ELS 2

// entries per fetch queue, a power of two.
`define QUEUE_ELS 8

`define PC_WIDTH 16
`define DATA_WIDTH 16

`endif

/* multi_core_pkg.sv */
/*
 * Instruction types shared by the dispatcher, the fetch queues and the tiles.
 * A fetched word is read as an ALU form or a control form by its top bit.
 */
package multi_core_pkg;

   typedef enum logic [2:0] {
      op_add  = 3'd0,   // acc + imm.
      op_sub  = 3'd1,   // acc - imm.
      op_xor  = 3'd2,   // acc ^ imm.
      op_load = 3'd3    // acc = imm, codes 4..7 leave acc alone.
   } alu_op_e;

   typedef enum logic {
      ctl_mark   = 1'b0,
      ctl_replay = 1'b1
   } ctl_kind_e;

   typedef struct packed {
      logic        cls;   // 0 for this form.
      alu_op_e     op;
      logic [11:0] imm;
   } alu_instr_s;

   typedef struct packed {
      logic        cls;   // 1 for this form.
      ctl_kind_e   kind;
      logic [13:0] unused;
   } ctl_instr_s;

   typedef union packed {
      alu_instr_s alu;
      ctl_instr_s ctl;
   } instr_u;

endpackage

/* fetch_dispatch.sv */
/*
 * Single staging register between the fetch stream and the per-core queues.
 * The staged word is offered only to the queue of its tagged core.
 */
`timescale 1ns/10ps
`include "multi_core_settings.svh"

module fetch_dispatch #(
   localparam int core_id_width_lp = (`CORE_ELS > 1) ? $clog2(`CORE_ELS) : 1
) (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          fetch_v_i,
   input  logic [core_id_width_lp-1:0]   fetch_core_i,
   input  logic [`PC_WIDTH-1:0]          fetch_pc_i,
   input  multi_core_pkg::instr_u        fetch_instr_i,
   output logic                          fetch_ready_o,
   input  logic [`CORE_ELS-1:0]          enq_ready_i,
   output logic [`CORE_ELS-1:0]          enq_v_o,
   output logic [`PC_WIDTH-1:0]          enq_pc_o,
   output multi_core_pkg::instr_u        enq_instr_o
);
   import multi_core_pkg::*;

   logic                        stage_v_r;
   logic [core_id_width_lp-1:0] stage_core_r;
   logic [`PC_WIDTH-1:0]        stage_pc_r;
   instr_u                      stage_instr_r;
   logic                        stage_leave;

   assign stage_leave   = stage_v_r & enq_ready_i[stage_core_r];
   assign fetch_ready_o = ~stage_v_r | stage_leave;   // empty or emptying.

   always_comb begin
      enq_v_o = '0;
      if (stage_v_r) enq_v_o[stage_core_r] = 1'b1;
   end

   assign enq_pc_o    = stage_pc_r;
   assign enq_instr_o = stage_instr_r;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         stage_v_r <= 1'b0;
      end else if (fetch_ready_o) begin
         stage_v_r <= fetch_v_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fetch_v_i && fetch_ready_o) begin
         stage_core_r  <= fetch_core_i;
         stage_pc_r    <= fetch_pc_i;
         stage_instr_r <= fetch_instr_i;
      end
   end

endmodule

/* fe_queue_rolly.sv */
/*
 * Circular fetch queue with a checkpoint pointer behind the read pointer.
 * ckpt_inc_i retires one read entry, roll_i re-reads from the checkpoint.
 */
`timescale 1ns/10ps
`include "multi_core_settings.svh"

module fe_queue_rolly (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    ckpt_inc_i,
   input  logic                    roll_i,
   input  logic                    enq_v_i,
   input  logic [`PC_WIDTH-1:0]    enq_pc_i,
   input  multi_core_pkg::instr_u  enq_instr_i,
   output logic                    enq_ready_o,
   input  logic                    deq_i,
   output logic                    deq_v_o,
   output logic [`PC_WIDTH-1:0]    deq_pc_o,
   output multi_core_pkg::instr_u  deq_instr_o
);
   import multi_core_pkg::*;

   localparam int idx_width_lp = $clog2(`QUEUE_ELS);

   // pointers carry one wrap bit above the index.
   logic [idx_width_lp:0]   wptr_r;
   logic [idx_width_lp:0]   rptr_r;
   logic [idx_width_lp:0]   cptr_r;
   logic [idx_width_lp:0]   cptr_next;
   logic [`PC_WIDTH-1:0]    pc_mem [`QUEUE_ELS];
   instr_u                  instr_mem [`QUEUE_ELS];
   logic                    full;
   logic                    enq_fire;

   // full against the checkpoint so uncommitted entries survive.
   assign full = (wptr_r[idx_width_lp] != cptr_r[idx_width_lp]) &&
                 (wptr_r[idx_width_lp-1:0] == cptr_r[idx_width_lp-1:0]);

   assign enq_ready_o = ~full;
   assign enq_fire    = enq_v_i & ~full;

   assign deq_v_o     = (rptr_r != wptr_r);
   assign deq_pc_o    = pc_mem[rptr_r[idx_width_lp-1:0]];
   assign deq_instr_o = instr_mem[rptr_r[idx_width_lp-1:0]];

   assign cptr_next = ckpt_inc_i ? cptr_r + 1'b1 : cptr_r;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wptr_r <= '0;
         rptr_r <= '0;
         cptr_r <= '0;
      end else begin
         if (enq_fire) wptr_r <= wptr_r + 1'b1;
         if (roll_i) begin
            rptr_r <= cptr_next;   // roll wins over a dequeue.
         end else if (deq_i && deq_v_o) begin
            rptr_r <= rptr_r + 1'b1;
         end
         cptr_r <= cptr_next;
      end
   end

   always_ff @(posedge clk_i) begin
      if (enq_fire) begin
         pc_mem[wptr_r[idx_width_lp-1:0]]    <= enq_pc_i;
         instr_mem[wptr_r[idx_width_lp-1:0]] <= enq_instr_i;
      end
   end

endmodule

/* core_tile.sv */
/*
 * One core: a rolly fetch queue feeding a one-entry execute stage.
 * The execute entry holds the next accumulator until its commit handshake.
 * A first-time replay word rolls the queue back once instead of committing.
 */
`timescale 1ns/10ps
`include "multi_core_settings.svh"

module core_tile (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    enq_v_i,
   input  logic [`PC_WIDTH-1:0]    enq_pc_i,
   input  multi_core_pkg::instr_u  enq_instr_i,
   output logic                    enq_ready_o,
   output logic                    cmt_v_o,
   input  logic                    cmt_ready_i,
   output logic [`PC_WIDTH-1:0]    cmt_pc_o,
   output logic [`DATA_WIDTH-1:0]  cmt_value_o,
   output logic                    replay_o
);
   import multi_core_pkg::*;

   logic                    deq_v;
   logic                    deq;
   logic [`PC_WIDTH-1:0]    deq_pc;
   instr_u                  head;
   logic                    ex_v_r;
   logic                    ex_roll_r;
   logic                    replayed_r;
   logic [`PC_WIDTH-1:0]    ex_pc_r;
   logic [`DATA_WIDTH-1:0]  ex_next_r;
   logic [`DATA_WIDTH-1:0]  acc_r;
   logic [`DATA_WIDTH-1:0]  acc_base;
   logic [`DATA_WIDTH-1:0]  next_acc;
   logic [`DATA_WIDTH-1:0]  imm_ext;
   logic                    cmt_fire;
   logic                    head_roll;

   fe_queue_rolly queue (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ckpt_inc_i  (cmt_fire),
      .roll_i      (replay_o),
      .enq_v_i     (enq_v_i),
      .enq_pc_i    (enq_pc_i),
      .enq_instr_i (enq_instr_i),
      .enq_ready_o (enq_ready_o),
      .deq_i       (deq),
      .deq_v_o     (deq_v),
      .deq_pc_o    (deq_pc),
      .deq_instr_o (head)
   );

   assign cmt_v_o     = ex_v_r & ~ex_roll_r;
   assign cmt_pc_o    = ex_pc_r;
   assign cmt_value_o = ex_next_r;
   assign replay_o    = ex_v_r & ex_roll_r;
   assign cmt_fire    = cmt_v_o & cmt_ready_i;
   assign deq         = deq_v & (~ex_v_r | cmt_fire);

   // forward the committing value so back-to-back words see it.
   assign acc_base = cmt_fire ? ex_next_r : acc_r;
   assign imm_ext  = `DATA_WIDTH'(head.alu.imm);

   always_comb begin
      next_acc  = acc_base;
      head_roll = 1'b0;
      if (!head.alu.cls) begin
         case (head.alu.op)
            op_add:  next_acc = acc_base + imm_ext;
            op_sub:  next_acc = acc_base - imm_ext;
            op_xor:  next_acc = acc_base ^ imm_ext;
            op_load: next_acc = imm_ext;
            default: next_acc = acc_base;
         endcase
      end else begin
         // the flag clears when the replayed word commits this cycle.
         head_roll = (head.ctl.kind == ctl_replay) && !(replayed_r && !cmt_fire);
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ex_v_r     <= 1'b0;
         ex_roll_r  <= 1'b0;
         replayed_r <= 1'b0;
         acc_r      <= '0;
      end else begin
         if (deq) begin
            ex_v_r    <= 1'b1;
            ex_roll_r <= head_roll;
         end else if (cmt_fire || replay_o) begin
            ex_v_r <= 1'b0;   // committed or discarded.
         end
         if (cmt_fire) acc_r <= ex_next_r;
         if (replay_o) begin
            replayed_r <= 1'b1;
         end else if (cmt_fire) begin
            replayed_r <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (deq) begin
         ex_pc_r   <= deq_pc;
         ex_next_r <= next_acc;
      end
   end

endmodule

/* commit_arbiter.sv */
/*
 * Round-robin merge of the tile commit ports onto one registered port.
 * The search starts after the last granted core.
 */
`timescale 1ns/10ps
`include "multi_core_settings.svh"

module commit_arbiter #(
   localparam int core_id_width_lp = (`CORE_ELS > 1) ? $clog2(`CORE_ELS) : 1
) (
   input  logic                               clk_i,
   input  logic                               rst_i,
   input  logic [`CORE_ELS-1:0]               cmt_v_i,
   input  logic [`CORE_ELS*`PC_WIDTH-1:0]     cmt_pc_i,
   input  logic [`CORE_ELS*`DATA_WIDTH-1:0]   cmt_value_i,
   output logic [`CORE_ELS-1:0]               cmt_ready_o,
   output logic                               commit_v_o,
   input  logic                               commit_ready_i,
   output logic [core_id_width_lp-1:0]        commit_core_o,
   output logic [`PC_WIDTH-1:0]               commit_pc_o,
   output logic [`DATA_WIDTH-1:0]             commit_value_o
);

   logic                        out_v_r;
   logic [core_id_width_lp-1:0] last_r;   // also the core of the output entry.
   logic [`PC_WIDTH-1:0]        out_pc_r;
   logic [`DATA_WIDTH-1:0]      out_value_r;
   logic [core_id_width_lp-1:0] grant_idx;
   logic                        found;
   logic                        out_free;
   logic                        grant_v;

   assign out_free = ~out_v_r | commit_ready_i;
   assign grant_v  = found & out_free;

   always_comb begin
      int idx;
      found     = 1'b0;
      grant_idx = last_r;
      for (int i = 1; i <= `CORE_ELS; i++) begin
         idx = (int'(last_r) + i) % `CORE_ELS;
         if (!found && cmt_v_i[idx]) begin
            found     = 1'b1;
            grant_idx = core_id_width_lp'(idx);
         end
      end
   end

   always_comb begin
      cmt_ready_o = '0;
      if (grant_v) cmt_ready_o[grant_idx] = 1'b1;
   end

   assign commit_v_o     = out_v_r;
   assign commit_core_o  = last_r;
   assign commit_pc_o    = out_pc_r;
   assign commit_value_o = out_value_r;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         out_v_r <= 1'b0;
         last_r  <= '0;
      end else if (out_free) begin
         out_v_r <= grant_v;
         if (grant_v) last_r <= grant_idx;
      end
   end

   always_ff @(posedge clk_i) begin
      if (grant_v) begin
         out_pc_r    <= cmt_pc_i[grant_idx*`PC_WIDTH +: `PC_WIDTH];
         out_value_r <= cmt_value_i[grant_idx*`DATA_WIDTH +: `DATA_WIDTH];
      end
   end

endmodule

/* multi_core_wrapper.sv */
/*
 * Top level of the multi-core model.
 * Fetch dispatch feeds CORE_ELS tiles, whose commits merge on one port.
 */
`timescale 1ns/10ps
`include "multi_core_settings.svh"

module multi_core_wrapper #(
   localparam int core_id_width_lp = (`CORE_ELS > 1) ? $clog2(`CORE_ELS) : 1
) (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          fetch_v_i,
   input  logic [core_id_width_lp-1:0]   fetch_core_i,
   input  logic [`PC_WIDTH-1:0]          fetch_pc_i,
   input  multi_core_pkg::instr_u        fetch_instr_i,
   output logic                          fetch_ready_o,
   output logic                          commit_v_o,
   input  logic                          commit_ready_i,
   output logic [core_id_width_lp-1:0]   commit_core_o,
   output logic [`PC_WIDTH-1:0]          commit_pc_o,
   output logic [`DATA_WIDTH-1:0]        commit_value_o,
   output logic [`CORE_ELS-1:0]          replay_o
);
   import multi_core_pkg::*;

   logic [`CORE_ELS-1:0]             enq_v;
   logic [`CORE_ELS-1:0]             enq_ready;
   logic [`PC_WIDTH-1:0]             enq_pc;
   instr_u                           enq_instr;
   logic [`CORE_ELS-1:0]             cmt_v;
   logic [`CORE_ELS-1:0]             cmt_ready;
   logic [`CORE_ELS*`PC_WIDTH-1:0]   cmt_pc;
   logic [`CORE_ELS*`DATA_WIDTH-1:0] cmt_value;

   fetch_dispatch dispatch (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .fetch_v_i     (fetch_v_i),
      .fetch_core_i  (fetch_core_i),
      .fetch_pc_i    (fetch_pc_i),
      .fetch_instr_i (fetch_instr_i),
      .fetch_ready_o (fetch_ready_o),
      .enq_ready_i   (enq_ready),
      .enq_v_o       (enq_v),
      .enq_pc_o      (enq_pc),
      .enq_instr_o   (enq_instr)
   );

   // enq buses are shared, only enq_v selects the tile.
   for (genvar k = 0; k < `CORE_ELS; k++) begin : core
      core_tile tile (
         .clk_i       (clk_i),
         .rst_i       (rst_i),
         .enq_v_i     (enq_v[k]),
         .enq_pc_i    (enq_pc),
         .enq_instr_i (enq_instr),
         .enq_ready_o (enq_ready[k]),
         .cmt_v_o     (cmt_v[k]),
         .cmt_ready_i (cmt_ready[k]),
         .cmt_pc_o    (cmt_pc[k*`PC_WIDTH +: `PC_WIDTH]),
         .cmt_value_o (cmt_value[k*`DATA_WIDTH +: `DATA_WIDTH]),
         .replay_o    (replay_o[k])
      );
   end

   commit_arbiter arbiter (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .cmt_v_i        (cmt_v),
      .cmt_pc_i       (cmt_pc),
      .cmt_value_i    (cmt_value),
      .cmt_ready_o    (cmt_ready),
      .commit_v_o     (commit_v_o),
      .commit_ready_i (commit_ready_i),
      .commit_core_o  (commit_core_o),
      .commit_pc_o    (commit_pc_o),
      .commit_value_o (commit_value_o)
   );

endmodule

/* multi_core_checker.sv */
/*
 * Commit checker for the multi-core testbench. The testbench posts each
 * fetch with its expected value, and every accepted commit is matched
 * against the oldest outstanding entry of its own core.
 */
`timescale 1ns/10ps
`include "multi_core_settings.svh"

module multi_core_checker #(
   localparam int core_id_width_lp = (`CORE_ELS > 1) ? $clog2(`CORE_ELS) : 1
) (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          commit_v_i,
   input  logic                          commit_ready_i,
   input  logic [core_id_width_lp-1:0]   commit_core_i,
   input  logic [`PC_WIDTH-1:0]          commit_pc_i,
   input  logic [`DATA_WIDTH-1:0]        commit_value_i,
   input  logic [`CORE_ELS-1:0]          replay_i
);

   int                     exp_core_q [$];
   logic [`PC_WIDTH-1:0]   exp_pc_q [$];
   logic [`DATA_WIDTH-1:0] exp_value_q [$];
   int                     replay_exp [`CORE_ELS];
   int                     replay_seen [`CORE_ELS];
   int                     mismatches;
   int                     failures;

   task automatic expect_commit(input int core, input logic [`PC_WIDTH-1:0] pc,
                                input logic [`DATA_WIDTH-1:0] value);
      exp_core_q.push_back(core);
      exp_pc_q.push_back(pc);
      exp_value_q.push_back(value);
   endtask

   task automatic expect_replay(input int core);
      replay_exp[core]++;
   endtask

   function automatic int pending();
      return exp_core_q.size();
   endfunction

   task automatic check_commit();
      int idx;
      idx = -1;
      for (int i = 0; i < exp_core_q.size(); i++) begin
         if (idx < 0 && exp_core_q[i] == int'(commit_core_i)) idx = i;   // oldest of this core.
      end
      if (idx < 0) begin
         failures++;
         $display("core %0d committed pc 0x%h with no fetch outstanding",
                  commit_core_i, commit_pc_i);
      end else begin
         if (commit_pc_i !== exp_pc_q[idx]) begin
            mismatches++;
            $display("mismatch commit_pc_o core %0d: got 0x%h expected 0x%h",
                     commit_core_i, commit_pc_i, exp_pc_q[idx]);
         end
         if (commit_value_i !== exp_value_q[idx]) begin
            mismatches++;
            $display("mismatch commit_value_o core %0d pc 0x%h: got 0x%h expected 0x%h",
                     commit_core_i, exp_pc_q[idx], commit_value_i, exp_value_q[idx]);
         end
         exp_core_q.delete(idx);
         exp_pc_q.delete(idx);
         exp_value_q.delete(idx);
      end
   endtask

   always @(posedge clk_i) begin
      if (!rst_i) begin
         for (int k = 0; k < `CORE_ELS; k++) begin
            if (replay_i[k]) replay_seen[k]++;
         end
         if (commit_v_i && commit_ready_i) check_commit();
      end
   end

   task automatic final_check();
      for (int k = 0; k < `CORE_ELS; k++) begin
         if (replay_seen[k] != replay_exp[k]) begin
            mismatches++;
            $display("mismatch replay_o[%0d] pulse count: got 0x%h expected 0x%h",
                     k, replay_seen[k], replay_exp[k]);
         end
      end
      if (exp_core_q.size() != 0) begin
         failures++;
         $display("%0d expected commits never arrived", exp_core_q.size());
      end
   endtask

endmodule

/* multi_core_assertions.sv */
/*
 * Concurrent checks on the wrapper handshakes, bound into multi_core_wrapper.
 */
`timescale 1ns/10ps
`include "multi_core_settings.svh"

module multi_core_assertions #(
   localparam int core_id_width_lp = (`CORE_ELS > 1) ? $clog2(`CORE_ELS) : 1
) (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          fetch_ready_i,
   input  logic [`CORE_ELS-1:0]          enq_v_i,
   input  logic [`CORE_ELS-1:0]          cmt_v_i,
   input  logic                          commit_v_i,
   input  logic                          commit_ready_i,
   input  logic [core_id_width_lp-1:0]   commit_core_i,
   input  logic [`PC_WIDTH-1:0]          commit_pc_i,
   input  logic [`DATA_WIDTH-1:0]        commit_value_i,
   input  logic [`CORE_ELS-1:0]          replay_i
);

   reset_clears_valids: assert property (@(posedge clk_i)
      rst_i |=> !commit_v_i && fetch_ready_i && enq_v_i == '0 && cmt_v_i == '0 &&
                replay_i == '0)
      else $error("valid outputs not cleared after reset");

   // a stalled commit keeps its payload.
   commit_held_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      commit_v_i && !commit_ready_i |=> commit_v_i && $stable(commit_core_i) &&
                                        $stable(commit_pc_i) && $stable(commit_value_i))
      else $error("commit payload changed while stalled");

   for (genvar k = 0; k < `CORE_ELS; k++) begin : replay_pulse
      one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
         replay_i[k] |=> !replay_i[k])
         else $error("replay_o[%0d] held for more than one cycle", k);
   end

endmodule

bind multi_core_wrapper multi_core_assertions assertions (
   .clk_i          (clk_i),
   .rst_i          (rst_i),
   .fetch_ready_i  (fetch_ready_o),
   .enq_v_i        (enq_v),
   .cmt_v_i        (cmt_v),
   .commit_v_i     (commit_v_o),
   .commit_ready_i (commit_ready_i),
   .commit_core_i  (commit_core_o),
   .commit_pc_i    (commit_pc_o),
   .commit_value_i (commit_value_o),
   .replay_i       (replay_o)
);

/* multi_core_tb.sv */
/*
 * Testbench for multi_core_wrapper. Applies a table of tagged fetches with
 * random gaps and random commit back-pressure, and leaves the comparing to
 * multi_core_checker.
 */
`timescale 1ns/10ps
`include "multi_core_settings.svh"

module multi_core_tb;

   localparam int core_id_width_lp = (`CORE_ELS > 1) ? $clog2(`CORE_ELS) : 1;
   localparam int rows_lp = 24;
   localparam int cycle_limit_lp = rows_lp * 40 + 200;

   // columns: core, pc, instruction word, expected commit value.
   localparam logic [63:0] stim_table [rows_lp] = '{
      64'h0000_0100_0123_0123,   // add.
      64'h0001_0200_3abc_0abc,   // load.
      64'h0000_0102_1023_0100,   // sub.
      64'h0001_0202_20f0_0a4c,   // xor.
      64'h0000_0104_8000_0100,   // mark.
      64'h0001_0204_c000_0a4c,   // replay.
      64'h0001_0206_0004_0a50,
      64'h0000_0106_5fff_0100,   // reserved op 5.
      64'h0000_0108_1200_ff00,   // sub wraps below zero.
      64'h0000_010a_2fff_f0ff,
      64'h0000_010c_c000_f0ff,
      64'h0000_010e_0001_f100,
      64'h0000_0110_3055_0055,
      64'h0000_0112_0fff_1054,
      64'h0000_0114_8abc_1054,   // mark with junk in the unused bits.
      64'h0001_0208_1a50_0000,
      64'h0001_020a_1001_ffff,
      64'h0001_020c_7123_ffff,   // reserved op 7.
      64'h0001_020e_c000_ffff,
      64'h0001_0210_200f_fff0,
      64'h0001_0212_0010_0000,   // add wraps past the top.
      64'h0000_0116_c123_1054,
      64'h0000_0118_0100_1154,
      64'h0001_0214_8000_0000
   };

   logic                        clk_i;
   logic                        rst_i;
   logic                        fetch_v_i;
   logic [core_id_width_lp-1:0] fetch_core_i;
   logic [`PC_WIDTH-1:0]        fetch_pc_i;
   logic [15:0]                 fetch_instr_i;
   logic                        fetch_ready_o;
   logic                        commit_v_o;
   logic                        commit_ready_i;
   logic [core_id_width_lp-1:0] commit_core_o;
   logic [`PC_WIDTH-1:0]        commit_pc_o;
   logic [`DATA_WIDTH-1:0]      commit_value_o;
   logic [`CORE_ELS-1:0]        replay_o;
   integer                      seed;
   int                          gap;
   int                          cycle_count;
   int                          run_failures;
   logic [63:0]                 row;

   multi_core_wrapper dut (.*);

   multi_core_checker commit_check (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .commit_v_i     (commit_v_o),
      .commit_ready_i (commit_ready_i),
      .commit_core_i  (commit_core_o),
      .commit_pc_i    (commit_pc_o),
      .commit_value_i (commit_value_o),
      .replay_i       (replay_o)
   );

   task automatic close_run();
      int other;
      other = commit_check.failures + run_failures;
      $display("errors: %0d mismatch, %0d other", commit_check.mismatches, other);
      if (commit_check.mismatches == 0 && other == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   endtask

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   // stall the commit port on about a third of the cycles.
   initial begin
      forever begin
         @(negedge clk_i);
         commit_ready_i = ($unsigned($random(seed)) % 3) != 0;
      end
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < cycle_limit_lp) begin
         @(posedge clk_i);
         cycle_count++;
      end
      run_failures++;
      $display("timeout: run did not finish within %0d cycles", cycle_limit_lp);
      close_run();
   end

   initial begin
      seed           = 32'hef3cbe80;
      run_failures   = 0;
      rst_i          = 1'b1;
      fetch_v_i      = 1'b0;
      fetch_core_i   = '0;
      fetch_pc_i     = '0;
      fetch_instr_i  = '0;
      commit_ready_i = 1'b0;
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      for (int r = 0; r < rows_lp; r++) begin
         row = stim_table[r];
         commit_check.expect_commit(int'(row[63:48]), row[47:32], row[15:0]);
         if (row[31] && row[30]) commit_check.expect_replay(int'(row[63:48]));
         fetch_v_i     = 1'b1;
         fetch_core_i  = row[48 +: core_id_width_lp];
         fetch_pc_i    = row[47:32];
         fetch_instr_i = row[31:16];
         // ready is stable between edges, so look at it on the falling edge.
         while (!fetch_ready_o) @(negedge clk_i);
         @(posedge clk_i);
         gap = int'($unsigned($random(seed)) % 4);
         @(negedge clk_i);
         fetch_v_i = 1'b0;
         repeat (gap) @(negedge clk_i);
      end
      while (commit_check.pending() != 0) @(posedge clk_i);
      repeat (20) @(posedge clk_i);   // room for a stray duplicate commit.
      if (!fetch_ready_o) begin
         run_failures++;
         $display("fetch_ready_o is still low after all commits drained");
      end
      commit_check.final_check();
      close_run();
   end

endmodule

/* compile.f */
+incdir+.
multi_core_pkg.sv
fetch_dispatch.sv
fe_queue_rolly.sv
core_tile.sv
commit_arbiter.sv
multi_core_wrapper.sv
multi_core_checker.sv
multi_core_assertions.sv
multi_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the multi-core testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert -Wno-fatal -f compile.f \
   --top-module multi_core_tb -o multi_core_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/multi_core_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Finished with no errors" "$log"; then
   exit 0
fi
exit 1
